//--- layerMixer.sv
`timescale 1ns/10ps

module layerMixer import tilemapPkg::*; (
	input logic HA2,
	input logic rst,
	// CPU write strobe for the priority registers
	input logic latch,
	input regAddr ca,
	// Priority value rides on mdi bits 3..1
	input colourAttr mdi,
	// Layer A pixel and colour
	input pixelCode pixA,
	input colourAttr colA,
	// Layer B pixel and colour
	input pixelCode pixB,
	input colourAttr colB,
	// Chain input from the previous generator
	input priLevel pri,
	input colourAttr cli,
	input pixelCode dti,
	// Chain output, registered
	output priLevel pro,
	output colourAttr clo,
	output pixelCode dto
);

	// Layer priority registers
	priLevel prA;
	priLevel prB;

	// Winner of A against B
	logic selB;
	priLevel layPri;
	colourAttr layCol;
	pixelCode layPix;

	// Layer winner against the chain
	logic takeLayer;

	//////////////////////////////////////////////////////////////////////
	// Priority registers
	//////////////////////////////////////////////////////////////////////

	// Unknown addresses leave both registers alone
	always_ff @(posedge HA2) begin
		if (rst) begin
			prA <= '0;
			prB <= '0;
		end else if (latch) begin
			case (ca)
				PRI_A_ADDR: prA <= mdi[3:1];
				PRI_B_ADDR: prB <= mdi[3:1];
				default: begin
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Layer resolution
	//////////////////////////////////////////////////////////////////////

	// B needs an opaque pixel and a strictly higher priority
	// On a tie A keeps the pixel
	assign selB = (pixB != TRANSPARENT) && (prB > prA);

	always_comb begin
		if (selB) begin
			layPri = prB;
			layCol = colB;
			layPix = pixB;
		end else begin
			layPri = prA;
			layCol = colA;
			layPix = pixA;
		end
	end

	// Same rule against the chain
	// Chain wins ties and covers a transparent layer pixel
	assign takeLayer = (layPix != TRANSPARENT) && (layPri > pri);

	//////////////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////////////

	// Decision is visible one clock after its inputs
	always_ff @(posedge HA2) begin
		if (rst) begin
			pro <= '0;
			clo <= '0;
			dto <= '0;
		end else if (takeLayer) begin
			pro <= layPri;
			clo <= layCol;
			dto <= layPix;
		end else begin
			// Pass the chain through
			pro <= pri;
			clo <= cli;
			dto <= dti;
		end
	end

endmodule

//--- planeShifter.sv
`timescale 1ns/10ps

module planeShifter import tilemapPkg::*; (
	input logic HA2,
	input logic rst,
	// First pixel of a new tile column
	input logic tileStart,
	// Horizontal flip, LSB leads when high
	input logic flip,
	// Held pattern and colour from the tile latch
	input patternWord pat,
	input colourAttr col,
	// Current pixel and colour of this layer
	output pixelCode pix,
	output colourAttr colOut
);

	// Three plane shift registers
	planeNibble plane0;
	planeNibble plane1;
	planeNibble plane2;

	// Colour of the tile being shifted out
	colourAttr colReg;

	// One step of a plane in the current direction
	// Vacated bit fills with zero
	function automatic planeNibble stepPlane(input planeNibble p, input logic dir);
		planeNibble r;
		if (dir) begin
			// Flipped, move towards bit 0
			r = {1'b0, p[3:1]};
		end else begin
			// Normal, move towards bit 3
			r = {p[2:0], 1'b0};
		end
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Plane registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge HA2) begin
		if (rst) begin
			plane0 <= '0;
			plane1 <= '0;
			plane2 <= '0;
			colReg <= '0;
		end else if (tileStart) begin
			// Reload from the word held before this edge
			plane0 <= pat[3:0];
			plane1 <= pat[7:4];
			plane2 <= pat[11:8];
			colReg <= col;
		end else begin
			// Advance one pixel
			plane0 <= stepPlane(plane0, flip);
			plane1 <= stepPlane(plane1, flip);
			plane2 <= stepPlane(plane2, flip);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Pixel output
	//////////////////////////////////////////////////////////////////////

	// Lead bit of each plane, plane 2 on top
	always_comb begin
		if (flip) begin
			pix = {plane2[0], plane1[0], plane0[0]};
		end else begin
			pix = {plane2[3], plane1[3], plane0[3]};
		end
	end

	// Colour stays fixed across the tile
	assign colOut = colReg;

endmodule

//--- tileLatch.sv
`timescale 1ns/10ps

module tileLatch import tilemapPkg::*; (
	input logic HA2,
	input logic rst,
	// Bus strobe, gdi and mdi are valid
	input logic load,
	// Destination of the load, 0 is A and 1 is B
	input logic layer,
	input patternWord gdi,
	input colourAttr mdi,
	// Held words for layer A
	output patternWord patA,
	output colourAttr colA,
	// Held words for layer B
	output patternWord patB,
	output colourAttr colB
);

	// Per-layer write enables
	logic loadA;
	logic loadB;

	// Only one layer takes the word on any load
	assign loadA = load && !layer;
	assign loadB = load && layer;

	// Layer A holding register
	// Keeps its value until the next load aimed at A
	always_ff @(posedge HA2) begin
		if (rst) begin
			patA <= '0;
			colA <= '0;
		end else if (loadA) begin
			patA <= gdi;
			colA <= mdi;
		end
	end

	// Layer B holding register
	// Same behaviour as A, selected by layer high
	always_ff @(posedge HA2) begin
		if (rst) begin
			patB <= '0;
			colB <= '0;
		end else if (loadB) begin
			patB <= gdi;
			colB <= mdi;
		end
	end

	// Shifters sample these on their own tileStart
	// A load on the same edge is seen one tile later

endmodule

//--- tilemapGen.f
tilemapPkg.sv
tileLatch.sv
planeShifter.sv
layerMixer.sv
tilemapGen.sv
tilemapGen_sva.sv
tilemapGenTb.sv

//--- tilemapGen.sv
`timescale 1ns/10ps

module tilemapGen import tilemapPkg::*; (
	input logic HA2,
	input logic rst,
	// Tile data bus
	input patternWord gdi,
	input colourAttr mdi,
	input logic load,
	input logic layer,
	// Pixel timing
	input logic tileStart,
	input logic flip,
	// Priority register write
	input logic latch,
	input regAddr ca,
	// Chain input
	input priLevel pri,
	input colourAttr cli,
	input pixelCode dti,
	// Chain output
	output priLevel pro,
	output colourAttr clo,
	output pixelCode dto
);

	// Held tile words, latch to shifters
	patternWord patA;
	colourAttr colA;
	patternWord patB;
	colourAttr colB;

	// Current pixels, shifters to mixer
	pixelCode pixA;
	colourAttr colOutA;
	pixelCode pixB;
	colourAttr colOutB;

	// Bus side capture for both layers
	tileLatch tileLatchInst (
		.HA2(HA2), .rst(rst), .load(load), .layer(layer),
		.gdi(gdi), .mdi(mdi),
		.patA(patA), .colA(colA), .patB(patB), .colB(colB)
	);

	// Layer A serialiser
	planeShifter shifterA (
		.HA2(HA2), .rst(rst), .tileStart(tileStart), .flip(flip),
		.pat(patA), .col(colA), .pix(pixA), .colOut(colOutA)
	);

	// Layer B serialiser, same timing as A
	planeShifter shifterB (
		.HA2(HA2), .rst(rst), .tileStart(tileStart), .flip(flip),
		.pat(patB), .col(colB), .pix(pixB), .colOut(colOutB)
	);

	// Priority mix with the chain
	layerMixer mixerInst (
		.HA2(HA2), .rst(rst), .latch(latch), .ca(ca), .mdi(mdi),
		.pixA(pixA), .colA(colOutA), .pixB(pixB), .colB(colOutB),
		.pri(pri), .cli(cli), .dti(dti),
		.pro(pro), .clo(clo), .dto(dto)
	);

endmodule

//--- tilemapGenTb.sv
`timescale 1ns/10ps

module tilemapGenTb import tilemapPkg::*; ();

	// Run lengths of each test phase, in clocks
	localparam logic [31:0] SEED = 32'hb67aee04;
	localparam int RESET_CYCLES = 10;
	localparam int FIXED_CYCLES = 36;
	localparam int SAME_EDGE_CYCLES = 16;
	localparam int PRI_CYCLES = 300;
	localparam int ADDR_CYCLES = 50;
	localparam int RANDOM_CYCLES = 3000;
	localparam int TOTAL_CYCLES = RESET_CYCLES + FIXED_CYCLES + SAME_EDGE_CYCLES
		+ PRI_CYCLES + ADDR_CYCLES + RANDOM_CYCLES;
	localparam int CYCLE_LIMIT = TOTAL_CYCLES + 100;

	// DUT inputs
	logic HA2;
	logic rst;
	patternWord gdi;
	colourAttr mdi;
	logic load;
	logic layer;
	logic tileStart;
	logic flip;
	logic latch;
	regAddr ca;
	priLevel pri;
	colourAttr cli;
	pixelCode dti;

	// DUT outputs
	priLevel pro;
	colourAttr clo;
	pixelCode dto;

	// Model state, index 0 is layer A and 1 is layer B
	patternWord mPat [0:1];
	colourAttr mAttr [0:1];
	colourAttr mHeld [0:1];
	planeNibble mPlane [0:1][0:2];
	priLevel mPrA;
	priLevel mPrB;
	priLevel mPro;
	colourAttr mClo;
	pixelCode mDto;

	int cycleCount = 0;

	// Fixed tile patterns for the ordering test
	patternWord fixedPat [0:3] = '{12'h3C5, 12'h9A6, 12'hF0F, 12'h7E1};

	tilemapGen tilemapGen_inst (
		.HA2(HA2), .rst(rst), .gdi(gdi), .mdi(mdi), .load(load), .layer(layer),
		.tileStart(tileStart), .flip(flip), .latch(latch), .ca(ca),
		.pri(pri), .cli(cli), .dti(dti),
		.pro(pro), .clo(clo), .dto(dto)
	);

	// 40 ns pixel clock
	always #20 HA2 = ~HA2;

	// Run limit
	always @(posedge HA2) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTBENCH FAILED");
			$fatal(1, "Run stopped on timeout");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic checkPri(input string name, input priLevel got, input priLevel exp);
		if (got !== exp) begin
			$display("CHECK FAILED: %s got %h expected %h", name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "Priority mismatch");
		end
	endtask

	task automatic checkCol(input string name, input colourAttr got, input colourAttr exp);
		if (got !== exp) begin
			$display("CHECK FAILED: %s got %h expected %h", name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "Colour mismatch");
		end
	endtask

	task automatic checkPix(input string name, input pixelCode got, input pixelCode exp);
		if (got !== exp) begin
			$display("CHECK FAILED: %s got %h expected %h", name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "Pixel mismatch");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Cycle model
	//////////////////////////////////////////////////////////////////////

	// Lead bit of each plane, plane 2 on top
	function automatic pixelCode leadPix(input int l);
		int b;
		b = flip ? 0 : 3;
		return {mPlane[l][2][b], mPlane[l][1][b], mPlane[l][0][b]};
	endfunction

	// One clock edge, using the inputs present before it
	task automatic updateModel();
		pixelCode pa;
		pixelCode pb;
		pixelCode winPix;
		priLevel winPri;
		colourAttr winCol;
		if (rst) begin
			for (int l = 0; l < 2; l++) begin
				mPat[l] = '0;
				mAttr[l] = '0;
				mHeld[l] = '0;
				for (int p = 0; p < 3; p++) begin
					mPlane[l][p] = '0;
				end
			end
			mPrA = '0;
			mPrB = '0;
			mPro = '0;
			mClo = '0;
			mDto = '0;
		end else begin
			pa = leadPix(0);
			pb = leadPix(1);
			// B over A only when opaque and strictly higher
			if (pb != TRANSPARENT && mPrB > mPrA) begin
				winPix = pb;
				winPri = mPrB;
				winCol = mHeld[1];
			end else begin
				winPix = pa;
				winPri = mPrA;
				winCol = mHeld[0];
			end
			// Layer over chain by the same rule, chain keeps ties
			if (winPix != TRANSPARENT && winPri > pri) begin
				mPro = winPri;
				mClo = winCol;
				mDto = winPix;
			end else begin
				mPro = pri;
				mClo = cli;
				mDto = dti;
			end
			if (latch && ca == PRI_A_ADDR) begin
				mPrA = mdi[3:1];
			end
			if (latch && ca == PRI_B_ADDR) begin
				mPrB = mdi[3:1];
			end
			// Shifters see the word held before this edge
			for (int l = 0; l < 2; l++) begin
				if (tileStart) begin
					mPlane[l][0] = mPat[l][3:0];
					mPlane[l][1] = mPat[l][7:4];
					mPlane[l][2] = mPat[l][11:8];
					mHeld[l] = mAttr[l];
				end else begin
					for (int p = 0; p < 3; p++) begin
						mPlane[l][p] = flip ? (mPlane[l][p] >> 1) : (mPlane[l][p] << 1);
					end
				end
			end
			if (load) begin
				mPat[layer] = gdi;
				mAttr[layer] = mdi;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// Edge, model step, compare, then the drive point 2 ns after the edge
	task automatic nextCycle();
		@(posedge HA2);
		updateModel();
		#1;
		if (!rst) begin
			checkPri("pro", pro, mPro);
			checkCol("clo", clo, mClo);
			checkPix("dto", dto, mDto);
		end
		#1;
	endtask

	task automatic clearStrobes();
		load = 1'b0;
		tileStart = 1'b0;
		latch = 1'b0;
	endtask

	// Small range so ties come up often
	function automatic priLevel narrowPri();
		return priLevel'($urandom_range(0, 3));
	endfunction

	task automatic randomChain();
		pri = narrowPri();
		cli = colourAttr'($urandom);
		if ($urandom_range(0, 3) == 0) begin
			dti = TRANSPARENT;
		end else begin
			dti = pixelCode'($urandom);
		end
	endtask

	task automatic randomLoad();
		logic [3:0] mask;
		mask = 4'($urandom);
		load = 1'b1;
		layer = 1'($urandom);
		// Masked columns become code 7 in every plane
		gdi = patternWord'($urandom) | {mask, mask, mask};
		mdi = colourAttr'($urandom);
	endtask

	// Any register address except the two priority registers
	function automatic regAddr otherAddr();
		regAddr a;
		a = regAddr'($urandom);
		if (a == PRI_A_ADDR || a == PRI_B_ADDR) begin
			a = a + 3'd1;
		end
		return a;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		HA2 = 1'b0;
		rst = 1'b1;
		gdi = '0;
		mdi = '0;
		load = 1'b0;
		layer = 1'b0;
		tileStart = 1'b0;
		flip = 1'b0;
		latch = 1'b0;
		ca = '0;
		pri = '0;
		cli = '0;
		dti = '0;
		void'($urandom(SEED));

		for (int i = 0; i < RESET_CYCLES; i++) begin
			nextCycle();
		end
		rst = 1'b0;
		// Outputs straight out of reset
		checkPri("pro", pro, priLevel'(0));
		checkCol("clo", clo, colourAttr'(0));
		checkPix("dto", dto, pixelCode'(0));

		// Fixed patterns, A at 6 above B at 2 and the chain at 0
		pri = 3'd0;
		cli = 8'h99;
		dti = 3'd2;
		clearStrobes();
		latch = 1'b1;
		ca = PRI_A_ADDR;
		mdi = 8'h0C;
		nextCycle();
		clearStrobes();
		latch = 1'b1;
		ca = PRI_B_ADDR;
		mdi = 8'h04;
		nextCycle();
		clearStrobes();
		load = 1'b1;
		layer = 1'b0;
		gdi = fixedPat[0];
		mdi = 8'h21;
		nextCycle();
		clearStrobes();
		load = 1'b1;
		layer = 1'b1;
		gdi = fixedPat[1];
		mdi = 8'h42;
		nextCycle();
		// Unflipped tiles first, then flipped
		for (int f = 0; f < 2; f++) begin
			for (int t = 0; t < 4; t++) begin
				for (int px = 0; px < 4; px++) begin
					clearStrobes();
					flip = f[0];
					tileStart = (px == 0);
					if (px == 1) begin
						load = 1'b1;
						layer = t[0];
						gdi = fixedPat[t];
						mdi = {6'h04, t[1:0]};
					end
					nextCycle();
				end
			end
		end

		// Load on the tileStart edge, shifter takes the older word
		flip = 1'b0;
		for (int t = 0; t < 4; t++) begin
			for (int px = 0; px < 4; px++) begin
				clearStrobes();
				tileStart = (px == 0);
				if (px == 0) begin
					load = 1'b1;
					layer = t[0];
					gdi = patternWord'($urandom);
					mdi = colourAttr'($urandom);
				end
				nextCycle();
			end
		end

		// Priority resolution with frequent ties and transparent pixels
		for (int i = 0; i < PRI_CYCLES; i++) begin
			clearStrobes();
			randomChain();
			if (i % 4 == 0) begin
				tileStart = 1'b1;
				flip = 1'($urandom);
			end
			if (i % 4 == 2) begin
				randomLoad();
			end
			if ($urandom_range(0, 2) == 0) begin
				latch = 1'b1;
				ca = ($urandom_range(0, 1) == 0) ? PRI_A_ADDR : PRI_B_ADDR;
				mdi = colourAttr'($urandom);
				mdi[3:1] = narrowPri();
			end
			nextCycle();
		end

		// Writes to unused addresses
		for (int i = 0; i < ADDR_CYCLES; i++) begin
			clearStrobes();
			randomChain();
			if (i % 4 == 0) begin
				tileStart = 1'b1;
			end
			if (i % 4 == 2) begin
				randomLoad();
			end
			latch = 1'b1;
			ca = otherAddr();
			mdi = colourAttr'($urandom);
			nextCycle();
		end
		checkPri("prA", tilemapGen_inst.mixerInst.prA, mPrA);
		checkPri("prB", tilemapGen_inst.mixerInst.prB, mPrB);

		// Long random run, tile starts at irregular spacing
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			clearStrobes();
			randomChain();
			tileStart = ($urandom_range(0, 3) == 0);
			if ($urandom_range(0, 15) == 0) begin
				flip = !flip;
			end
			if ($urandom_range(0, 2) == 0) begin
				randomLoad();
			end
			if ($urandom_range(0, 7) == 0) begin
				latch = 1'b1;
				ca = regAddr'($urandom);
				mdi = colourAttr'($urandom);
			end
			nextCycle();
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- tilemapGen_sva.sv
`timescale 1ns/10ps

module tilemapGenSva import tilemapPkg::*; (
	input logic HA2,
	input logic rst,
	// Registered outputs of the bound block, zero padded to one width
	input logic [13:0] outBits,
	// Mixer side
	input pixelCode dto,
	input pixelCode dti,
	input logic takeLayer,
	// Shifter side
	input logic tileStart,
	input logic flip,
	input patternWord pat,
	input pixelCode pix
);

	// Everything held in reset comes out as zero
	assert property (@(posedge HA2) ($past(rst) && !rst) |-> (outBits == '0))
		else $error("Outputs not zero in the first cycle after reset");

	// A transparent output can only come from the chain
	// A layer pixel of 7 always loses, so the chain pixel was 7 too
	assert property (@(posedge HA2) disable iff (rst)
		(dto == TRANSPARENT) |-> ($past(dti) == TRANSPARENT) && !$past(takeLayer))
		else $error("Transparent output without a transparent chain pixel");

	// First pixel of an unflipped tile is the top bit of each plane
	assert property (@(posedge HA2)
		(!rst && tileStart) ##1 (!rst && !flip) |->
		(pix == {$past(pat[11]), $past(pat[7]), $past(pat[3])}))
		else $error("Shifter lead pixel does not match the loaded planes");

endmodule

// Mixer side, shifter ports tied off
bind layerMixer tilemapGenSva mixerSva (
	.HA2(HA2), .rst(rst), .outBits({pro, clo, dto}),
	.dto(dto), .dti(dti), .takeLayer(takeLayer),
	.tileStart(1'b0), .flip(1'b0), .pat(12'h000), .pix(3'd0)
);

// Shifter side, mixer ports tied off
bind planeShifter tilemapGenSva shifterSva (
	.HA2(HA2), .rst(rst), .outBits({3'b000, pix, colOut}),
	.dto(3'd0), .dti(3'd0), .takeLayer(1'b0),
	.tileStart(tileStart), .flip(flip), .pat(pat), .pix(pix)
);

//--- tilemapPkg.sv
package tilemapPkg;

	//////////////////////////////////////////////////////////////////////
	// Pixel and tile widths
	//////////////////////////////////////////////////////////////////////

	// Colour index of one pixel inside a palette entry
	typedef logic [2:0] pixelCode;

	// Layer priority, compared against the other layer and the chain
	typedef logic [2:0] priLevel;

	// Palette or colour attribute of one tile column
	typedef logic [7:0] colourAttr;

	// Four pixels in three bit planes
	// Plane 0 in bits 3..0, plane 1 in 7..4, plane 2 in 11..8
	// Leftmost pixel is the MSB of each plane
	typedef logic [11:0] patternWord;

	// One plane of one tile column
	typedef logic [3:0] planeNibble;

	//////////////////////////////////////////////////////////////////////
	// CPU side register map
	//////////////////////////////////////////////////////////////////////

	// Register select on the CPU bus
	typedef logic [2:0] regAddr;

	// Layer A priority register
	localparam regAddr PRI_A_ADDR = 3'd1;

	// Layer B priority register
	localparam regAddr PRI_B_ADDR = 3'd5;

	// Pixel code that lets the layer below show through
	localparam pixelCode TRANSPARENT = 3'd7;

endpackage
